// ==== Makefile ====
TOP   = core_tb
FLIST = core_top.f

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f $(FLIST) --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== core_top.f ====
design/core_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/writeback_stage.sv
design/core_top.sv
verification/tb_clock.sv
verification/core_tb.sv

// ==== design/core_pkg.sv ====
package core_pkg;

    localparam int XLEN = 32;

    typedef logic [4:0] reg_addr_t;

    localparam logic [XLEN-1:0] REGPC_NOP = 32'hffff_ffff;  // Marks an empty slot.
    localparam logic [XLEN-1:0] INST_NOP  = 32'h0000_0013;  // addi x0, x0, 0.
    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;

    // Major opcodes in bits 6:0.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_JUMP
    } branch_op_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;

endpackage

// ==== design/core_top.sv ====
module core_top
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    output logic            mem_start,
    input  logic            mem_ready,
    output logic [XLEN-1:0] mem_addr,
    input  logic [XLEN-1:0] mem_data,
    input  logic            mem_data_valid,

    output logic            retire_valid,
    output logic [XLEN-1:0] retire_pc,
    output reg_addr_t       retire_rd,
    output logic [XLEN-1:0] retire_value
);

    logic [XLEN-1:0] id_reg_pc;
    logic [XLEN-1:0] id_inst;
    logic            stall_flg;
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    logic [XLEN-1:0] ex_pc;
    alu_op_e         ex_alu_op;
    branch_op_e      ex_branch_op;
    reg_addr_t       ex_rd;
    logic [XLEN-1:0] ex_op_a;
    logic [XLEN-1:0] ex_op_b;
    logic [XLEN-1:0] ex_offset;
    logic [XLEN-1:0] ex_rs2_val;

    logic [XLEN-1:0] wb_pc;
    reg_addr_t       wb_rd;
    logic [XLEN-1:0] wb_value;
    logic            wb_taken;
    logic [XLEN-1:0] wb_target;

    reg_addr_t       rd_addr;
    logic            rd_we;
    logic [XLEN-1:0] rd_data;
    logic            wb_branch_hazard;
    logic [XLEN-1:0] wb_reg_pc;

    fetch_stage u_fetch (
        .clk, .reset, .wb_reg_pc, .wb_branch_hazard, .stall_flg,
        .id_reg_pc, .id_inst,
        .mem_start, .mem_ready, .mem_addr, .mem_data, .mem_data_valid
    );

    decode_stage u_decode (
        .clk, .reset, .id_reg_pc, .id_inst, .wb_branch_hazard,
        .rs1_val, .rs2_val, .stall_flg, .rs1_addr, .rs2_addr,
        .ex_pc, .ex_alu_op, .ex_branch_op, .ex_rd,
        .ex_op_a, .ex_op_b, .ex_offset, .ex_rs2_val
    );

    register_file u_regs (
        .clk, .reset, .rs1_addr, .rs2_addr, .rs1_val, .rs2_val,
        .rd_addr, .rd_we, .rd_data
    );

    execute_stage u_execute (
        .clk, .reset, .ex_pc, .ex_alu_op, .ex_branch_op, .ex_rd,
        .ex_op_a, .ex_op_b, .ex_offset, .ex_rs2_val, .wb_branch_hazard,
        .wb_pc, .wb_rd, .wb_value, .wb_taken, .wb_target
    );

    writeback_stage u_writeback (
        .wb_pc, .wb_rd, .wb_value, .wb_taken, .wb_target,
        .rd_addr, .rd_we, .rd_data, .wb_branch_hazard, .wb_reg_pc,
        .retire_valid, .retire_pc, .retire_rd, .retire_value
    );

endmodule

// ==== design/decode_stage.sv ====
module decode_stage
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  logic [XLEN-1:0] id_reg_pc,
    input  logic [XLEN-1:0] id_inst,
    input  logic            wb_branch_hazard,

    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,

    output logic            stall_flg,
    output reg_addr_t       rs1_addr,
    output reg_addr_t       rs2_addr,

    output logic [XLEN-1:0] ex_pc,
    output alu_op_e         ex_alu_op,
    output branch_op_e      ex_branch_op,
    output reg_addr_t       ex_rd,
    output logic [XLEN-1:0] ex_op_a,
    output logic [XLEN-1:0] ex_op_b,
    output logic [XLEN-1:0] ex_offset,
    output logic [XLEN-1:0] ex_rs2_val
);

    logic            held_valid;
    logic [XLEN-1:0] held_pc;
    logic [XLEN-1:0] held_inst;

    logic [XLEN-1:0] cur_pc;
    logic [XLEN-1:0] cur_inst;
    logic            cur_valid;
    opcode_e         opcode;
    logic [2:0]      funct3;
    reg_addr_t       rd_field;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    alu_op_e         f3_alu_op;
    logic            f3_ok;
    logic            supported;
    logic            uses_rs1;
    logic            uses_rs2;
    alu_op_e         dec_alu_op;
    branch_op_e      dec_branch_op;
    reg_addr_t       dec_rd;
    logic [XLEN-1:0] dec_op_a;
    logic [XLEN-1:0] dec_op_b;
    logic [XLEN-1:0] dec_offset;

    // Fetch sends a bubble while a held word is pending.
    assign cur_pc    = held_valid ? held_pc : id_reg_pc;
    assign cur_inst  = held_valid ? held_inst : id_inst;
    assign cur_valid = (cur_pc != REGPC_NOP);

    assign opcode   = opcode_e'(cur_inst[6:0]);
    assign funct3   = cur_inst[14:12];
    assign rd_field = cur_inst[11:7];
    assign rs1_addr = cur_inst[19:15];
    assign rs2_addr = cur_inst[24:20];

    assign imm_i = {{20{cur_inst[31]}}, cur_inst[31:20]};
    assign imm_u = {cur_inst[31:12], 12'b0};
    assign imm_b = {{20{cur_inst[31]}}, cur_inst[7], cur_inst[30:25], cur_inst[11:8], 1'b0};
    assign imm_j = {{12{cur_inst[31]}}, cur_inst[19:12], cur_inst[20], cur_inst[30:21], 1'b0};

    // Shared by register and immediate forms.
    always_comb begin
        f3_alu_op = ALU_ADD;
        f3_ok     = 1'b1;
        case (funct3)
            F3_ADD_SUB: f3_alu_op = (opcode == OPC_OP && cur_inst[30]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     f3_alu_op = ALU_SLL;
            F3_SLT:     f3_alu_op = ALU_SLT;
            F3_XOR:     f3_alu_op = ALU_XOR;
            F3_SRL: begin
                f3_alu_op = ALU_SRL;
                f3_ok     = !cur_inst[30];  // Arithmetic shift not supported.
            end
            F3_OR:      f3_alu_op = ALU_OR;
            F3_AND:     f3_alu_op = ALU_AND;
            default:    f3_ok     = 1'b0;
        endcase
    end

    always_comb begin
        dec_alu_op    = f3_alu_op;
        dec_branch_op = BR_NONE;
        dec_rd        = rd_field;
        dec_op_a      = rs1_val;
        dec_op_b      = imm_i;
        dec_offset    = imm_b;
        supported     = 1'b1;
        uses_rs1      = 1'b0;
        uses_rs2      = 1'b0;
        case (opcode)
            OPC_OP: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                dec_op_b  = rs2_val;
                supported = f3_ok;
            end
            OPC_OP_IMM: begin
                uses_rs1  = 1'b1;
                supported = f3_ok;
            end
            OPC_LUI: begin
                dec_alu_op = ALU_ADD;
                dec_op_a   = '0;
                dec_op_b   = imm_u;
            end
            OPC_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                dec_rd   = '0;
                case (funct3)
                    F3_BEQ:  dec_branch_op = BR_BEQ;
                    F3_BNE:  dec_branch_op = BR_BNE;
                    F3_BLT:  dec_branch_op = BR_BLT;
                    default: supported     = 1'b0;
                endcase
            end
            OPC_JAL: begin
                dec_alu_op    = ALU_ADD;
                dec_branch_op = BR_JUMP;
                dec_op_a      = cur_pc;
                dec_op_b      = 32'd4;       // Link value.
                dec_offset    = imm_j;
            end
            default: supported = 1'b0;
        endcase
        if (!supported || !cur_valid) begin
            dec_rd        = '0;
            dec_branch_op = BR_NONE;
        end
    end

    assign stall_flg = cur_valid && (ex_rd != '0) &&
                       ((uses_rs1 && rs1_addr == ex_rd) || (uses_rs2 && rs2_addr == ex_rd));

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid   <= 1'b0;
            ex_pc        <= REGPC_NOP;
            ex_rd        <= '0;
            ex_branch_op <= BR_NONE;
        end else if (wb_branch_hazard || stall_flg) begin
            held_valid   <= stall_flg && !wb_branch_hazard;
            ex_pc        <= REGPC_NOP;
            ex_rd        <= '0;
            ex_branch_op <= BR_NONE;
        end else begin
            held_valid   <= 1'b0;
            ex_pc        <= cur_pc;
            ex_rd        <= dec_rd;
            ex_branch_op <= dec_branch_op;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op  <= dec_alu_op;
        ex_op_a    <= dec_op_a;
        ex_op_b    <= dec_op_b;
        ex_offset  <= dec_offset;
        ex_rs2_val <= rs2_val;
        if (stall_flg) begin
            held_pc   <= cur_pc;
            held_inst <= cur_inst;
        end
    end

endmodule

// ==== design/execute_stage.sv ====
module execute_stage
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  logic [XLEN-1:0] ex_pc,
    input  alu_op_e         ex_alu_op,
    input  branch_op_e      ex_branch_op,
    input  reg_addr_t       ex_rd,
    input  logic [XLEN-1:0] ex_op_a,
    input  logic [XLEN-1:0] ex_op_b,
    input  logic [XLEN-1:0] ex_offset,
    input  logic [XLEN-1:0] ex_rs2_val,
    input  logic            wb_branch_hazard,

    output logic [XLEN-1:0] wb_pc,
    output reg_addr_t       wb_rd,
    output logic [XLEN-1:0] wb_value,
    output logic            wb_taken,
    output logic [XLEN-1:0] wb_target
);

    logic [XLEN-1:0] alu_result;
    logic            taken;
    logic [XLEN-1:0] target;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_result = ex_op_a + ex_op_b;
            ALU_SUB: alu_result = ex_op_a - ex_op_b;
            ALU_AND: alu_result = ex_op_a & ex_op_b;
            ALU_OR:  alu_result = ex_op_a | ex_op_b;
            ALU_XOR: alu_result = ex_op_a ^ ex_op_b;
            ALU_SLT: alu_result = {31'b0, $signed(ex_op_a) < $signed(ex_op_b)};
            ALU_SLL: alu_result = ex_op_a << ex_op_b[4:0];
            ALU_SRL: alu_result = ex_op_a >> ex_op_b[4:0];
            default: alu_result = '0;
        endcase
    end

    // Branches compare rs1 against rs2.
    always_comb begin
        case (ex_branch_op)
            BR_BEQ:  taken = (ex_op_a == ex_rs2_val);
            BR_BNE:  taken = (ex_op_a != ex_rs2_val);
            BR_BLT:  taken = ($signed(ex_op_a) < $signed(ex_rs2_val));
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign target = ex_pc + ex_offset;

    always_ff @(posedge clk) begin
        if (reset || wb_branch_hazard) begin
            wb_pc    <= REGPC_NOP;  // Wrong-path slot becomes a bubble.
            wb_rd    <= '0;
            wb_taken <= 1'b0;
        end else begin
            wb_pc    <= ex_pc;
            wb_rd    <= ex_rd;
            wb_taken <= taken;
        end
    end

    always_ff @(posedge clk) begin
        wb_value  <= alu_result;
        wb_target <= target;
    end

endmodule

// ==== design/fetch_stage.sv ====
module fetch_stage
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    input  logic [XLEN-1:0] wb_reg_pc,
    input  logic            wb_branch_hazard,
    input  logic            stall_flg,

    output logic [XLEN-1:0] id_reg_pc,
    output logic [XLEN-1:0] id_inst,

    output logic            mem_start,
    input  logic            mem_ready,
    output logic [XLEN-1:0] mem_addr,
    input  logic [XLEN-1:0] mem_data,
    input  logic            mem_data_valid
);

    typedef enum logic {
        ST_WAIT_READY,
        ST_WAIT_VALID
    } fetch_state_e;

    fetch_state_e    state;
    logic [XLEN-1:0] inner_pc;      // Address of the open request, else the next one.
    logic            is_fetched;    // A word is parked in the saved slot.

    logic [XLEN-1:0] saved_pc;
    logic [XLEN-1:0] saved_inst;

    logic            got_word;
    logic            have_word;
    logic            bus_free;
    logic            want_issue;
    logic            pass_word;
    logic [XLEN-1:0] word_pc;
    logic [XLEN-1:0] word_inst;

    // Fresh data only counts when no word is parked.
    assign got_word  = (state == ST_WAIT_VALID) && !is_fetched && mem_data_valid;
    assign have_word = got_word || ((state == ST_WAIT_VALID) && is_fetched);

    assign word_pc   = got_word ? inner_pc : saved_pc;
    assign word_inst = got_word ? mem_data : saved_inst;

    // The word moves on only when decode takes it and no redirect kills it.
    assign pass_word = have_word && !stall_flg && !wb_branch_hazard;

    // No request is open after this cycle, so a new one may go out.
    assign bus_free   = (state == ST_WAIT_READY) || have_word;
    assign want_issue = wb_branch_hazard || (state == ST_WAIT_READY) || !stall_flg;

    assign mem_start = !reset && bus_free && want_issue && mem_ready;
    assign mem_addr  = wb_branch_hazard ? wb_reg_pc :
                       got_word         ? inner_pc + 32'd4 :
                                          inner_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_WAIT_READY;
            is_fetched <= 1'b0;
            inner_pc   <= RESET_PC;
            id_reg_pc  <= REGPC_NOP;
            id_inst    <= INST_NOP;
        end else begin
            id_reg_pc <= pass_word ? word_pc : REGPC_NOP;
            id_inst   <= pass_word ? word_inst : INST_NOP;

            if (mem_start) begin
                state      <= ST_WAIT_VALID;
                is_fetched <= 1'b0;
                inner_pc   <= mem_addr;
            end else if (wb_branch_hazard) begin
                // An open request is left to finish and its data is dropped.
                state      <= ST_WAIT_READY;
                is_fetched <= 1'b0;
                inner_pc   <= wb_reg_pc;
            end else if (got_word && stall_flg) begin
                is_fetched <= 1'b1;             // Park until decode moves.
                inner_pc   <= inner_pc + 32'd4;
            end else if (got_word) begin
                state      <= ST_WAIT_READY;
                inner_pc   <= inner_pc + 32'd4;
            end else if (is_fetched && !stall_flg) begin
                state      <= ST_WAIT_READY;
                is_fetched <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (got_word && stall_flg) begin
            saved_pc   <= inner_pc;
            saved_inst <= mem_data;
        end
    end

endmodule

// ==== design/register_file.sv ====
module register_file
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  reg_addr_t       rs1_addr,
    input  reg_addr_t       rs2_addr,
    output logic [XLEN-1:0] rs1_val,
    output logic [XLEN-1:0] rs2_val,
    input  reg_addr_t       rd_addr,
    input  logic            rd_we,
    input  logic [XLEN-1:0] rd_data
);

    logic [XLEN-1:0] regs [32];

    function automatic logic [XLEN-1:0] read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (rd_we && rd_addr == addr) begin
            return rd_data;     // Write-through.
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_val = read_port(rs1_addr);
        rs2_val = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

endmodule

// ==== design/writeback_stage.sv ====
module writeback_stage
    import core_pkg::*;
(
    input  logic [XLEN-1:0] wb_pc,
    input  reg_addr_t       wb_rd,
    input  logic [XLEN-1:0] wb_value,
    input  logic            wb_taken,
    input  logic [XLEN-1:0] wb_target,

    output reg_addr_t       rd_addr,
    output logic            rd_we,
    output logic [XLEN-1:0] rd_data,

    output logic            wb_branch_hazard,
    output logic [XLEN-1:0] wb_reg_pc,

    output logic            retire_valid,
    output logic [XLEN-1:0] retire_pc,
    output reg_addr_t       retire_rd,
    output logic [XLEN-1:0] retire_value
);

    logic slot_valid;

    assign slot_valid = (wb_pc != REGPC_NOP);

    assign rd_addr = wb_rd;
    assign rd_we   = slot_valid && (wb_rd != '0);
    assign rd_data = wb_value;

    assign wb_branch_hazard = slot_valid && wb_taken;
    assign wb_reg_pc        = wb_target;

    // Value reads zero when nothing is written.
    assign retire_valid = slot_valid;
    assign retire_pc    = wb_pc;
    assign retire_rd    = wb_rd;
    assign retire_value = rd_we ? wb_value : '0;

endmodule

// ==== verification/core_tb.sv ====
module core_tb
    import core_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_TESTS       = 6;
    localparam int TOTAL_RETIRES   = 1340;
    localparam int WATCHDOG_CYCLES = TOTAL_RETIRES * 20 + NUM_TESTS * 20;

    logic            clk;
    logic            reset;
    logic            mem_start;
    logic            mem_ready;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_data;
    logic            mem_data_valid;
    logic            retire_valid;
    logic [XLEN-1:0] retire_pc;
    reg_addr_t       retire_rd;
    logic [XLEN-1:0] retire_value;

    logic [XLEN-1:0] imem [256];
    logic [XLEN-1:0] m_regs [32];
    logic [XLEN-1:0] m_pc;

    logic            reset_req;
    logic            req_open;
    int              req_wait;
    logic [XLEN-1:0] req_addr;
    int              ready_low;
    logic            slow_mem;
    logic            first_req;

    int              errors;
    int              checks;
    int              retired;
    int              failed_tests;

    tb_clock u_clock (.clk);

    core_top DUT (
        .clk, .reset,
        .mem_start, .mem_ready, .mem_addr, .mem_data, .mem_data_valid,
        .retire_valid, .retire_pc, .retire_rd, .retire_value
    );

    task automatic check_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("At %0t the core misbehaved: %s", $time, what);
    endtask

    function automatic reg_addr_t pick_reg(input int lo, input int hi);
        return reg_addr_t'(lo + int'($urandom % (hi - lo + 1)));
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3,
                                          input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                          input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] gen_alu(input int lo, input int hi);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        rd  = pick_reg(lo, hi);
        rs1 = pick_reg(lo, hi);
        rs2 = pick_reg(lo, hi);
        f3  = 3'($urandom);
        imm = 12'($urandom);
        if (f3 == 3'b011) begin
            f3 = 3'b010;                // No unsigned compare.
        end
        case ($urandom % 3)
            0: begin
                f7 = (f3 == 3'b000 && $urandom % 2 == 0) ? 7'b0100000 : 7'b0000000;
                return enc_r(f7, rs2, rs1, f3, rd);
            end
            1: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {7'b0, imm[4:0]};     // Logical shift amount only.
                end
                return enc_i(imm, rs1, f3, rd);
            end
            default: return {20'($urandom), rd, OPC_LUI};
        endcase
    endfunction

    function automatic logic [31:0] gen_branch();
        int        off;
        reg_addr_t rs1;
        reg_addr_t rs2;
        off = int'($urandom % 12) - 3;
        if (off == 0) begin
            off = 1;
        end
        off = off * 4;
        rs1 = pick_reg(0, 7);
        rs2 = pick_reg(0, 7);
        case ($urandom % 4)
            0:       return enc_b(13'(off), rs2, rs1, 3'b000);
            1:       return enc_b(13'(off), rs2, rs1, 3'b001);
            2:       return enc_b(13'(off), rs2, rs1, 3'b100);
            default: return enc_j(21'(off), pick_reg(0, 7));
        endcase
    endfunction

    function automatic logic [31:0] gen_unsupported();
        logic [31:0] raw;
        raw = $urandom;
        case ($urandom % 7)
            0: return {raw[31:7], 7'b0000011};     // Load.
            1: return {raw[31:7], 7'b0100011};     // Store.
            2: return {raw[31:7], 7'b0010111};     // AUIPC.
            3: return {raw[31:7], 7'b1100111};     // JALR.
            4: return enc_r(7'b0000000, pick_reg(1, 7), pick_reg(1, 7), 3'b011, pick_reg(1, 7));
            5: return enc_r(7'b0100000, pick_reg(1, 7), pick_reg(1, 7), 3'b101, pick_reg(1, 7));
            default: return enc_b(13'd8, pick_reg(1, 7), pick_reg(1, 7), 3'b101);
        endcase
    endfunction

    // Kind 0 random ALU, 1 dense x1..x3, 2 branches, 3 unsupported mix.
    task automatic load_program(input int kind);
        for (int i = 0; i < 256; i++) begin
            case (kind)
                1:       imem[i] = gen_alu(1, 3);
                2:       imem[i] = ($urandom % 5 < 2) ? gen_branch() : gen_alu(0, 7);
                3:       imem[i] = ($urandom % 4 == 0) ? gen_unsupported() : gen_alu(1, 7);
                default: imem[i] = gen_alu(0, 31);
            endcase
        end
    endtask

    task automatic model_step(output logic [XLEN-1:0] pc, output reg_addr_t rd,
                              output logic [XLEN-1:0] value);
        logic [31:0]     inst;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] next_pc;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic            is_op;
        logic            writes;
        logic            taken;
        inst    = imem[m_pc[9:2]];
        is_op   = (inst[6:0] == OPC_OP);
        a       = m_regs[inst[19:15]];
        b       = is_op ? m_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
        imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        next_pc = m_pc + 32'd4;
        res     = '0;
        writes  = 1'b0;
        taken   = 1'b0;
        case (inst[6:0])
            OPC_OP, OPC_OP_IMM: begin
                writes = 1'b1;
                case (inst[14:12])
                    3'b000: res = (is_op && inst[30]) ? a - b : a + b;
                    3'b001: res = a << b[4:0];
                    3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100: res = a ^ b;
                    3'b101: begin
                        res    = a >> b[4:0];
                        writes = !inst[30];     // Arithmetic shift is outside the subset.
                    end
                    3'b110: res = a | b;
                    3'b111: res = a & b;
                    default: writes = 1'b0;
                endcase
            end
            OPC_LUI: begin
                writes = 1'b1;
                res    = {inst[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                b = m_regs[inst[24:20]];
                case (inst[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = m_pc + imm_b;
                end
            end
            OPC_JAL: begin
                writes  = 1'b1;
                res     = m_pc + 32'd4;
                next_pc = m_pc + imm_j;
            end
            default: writes = 1'b0;
        endcase
        pc    = m_pc;
        rd    = (writes && inst[11:7] != 5'd0) ? inst[11:7] : 5'd0;
        value = (rd != 5'd0) ? res : '0;
        if (rd != 5'd0) begin
            m_regs[rd] = res;
        end
        m_pc = next_pc;
    endtask

    // Memory side of one cycle, driven just after the falling edge.
    task automatic drive_memory();
        mem_data_valid = 1'b0;
        if (reset) begin
            req_open  = 1'b0;
            ready_low = 0;
            mem_ready = ($urandom % 4 != 0);
        end else if (req_open) begin
            req_wait--;
            if (req_wait == 0) begin
                req_open       = 1'b0;
                mem_data_valid = 1'b1;
                mem_data       = imem[req_addr[9:2]];
                mem_ready      = 1'b1;
            end else begin
                mem_ready = 1'b0;
            end
        end else if (ready_low > 0) begin
            ready_low--;
            mem_ready = 1'b0;
        end else if (slow_mem && $urandom % 4 == 0) begin
            ready_low = 4 + int'($urandom % 12);
            mem_ready = 1'b0;
        end else begin
            mem_ready = ($urandom % 4 != 0);
        end
    endtask

    task automatic step_cycle();
        logic [XLEN-1:0] exp_pc;
        reg_addr_t       exp_rd;
        logic [XLEN-1:0] exp_value;
        @(negedge clk);
        reset = reset_req;
        drive_memory();
        #1;
        if (mem_start && !mem_ready) begin
            report_failure("mem_start was raised while mem_ready was low");
        end
        if (mem_start && mem_ready && !reset) begin
            if (first_req) begin
                check_word("first fetch address", mem_addr, RESET_PC);
                first_req = 1'b0;
            end
            req_open = 1'b1;
            req_addr = mem_addr;
            req_wait = slow_mem ? 3 : 1 + int'($urandom % 3);
        end
        if (retire_valid && !reset) begin
            model_step(exp_pc, exp_rd, exp_value);
            check_word("retire_pc", retire_pc, exp_pc);
            check_reg("retire_rd", retire_rd, exp_rd);
            check_word("retire_value", retire_value, exp_value);
            retired++;
        end
    endtask

    task automatic reset_core();
        reset_req = 1'b1;
        for (int i = 0; i < 10; i++) begin
            step_cycle();
            if (i > 0 && (mem_start || retire_valid)) begin
                report_failure("mem_start or retire_valid was high during reset");
            end
        end
        reset_req = 1'b0;
        first_req = 1'b1;
        step_cycle();
        if (retire_valid) begin
            report_failure("retire_valid was high right after reset");
        end
    endtask

    task automatic run_test(input string name, input int kind, input int count,
                            input logic slow);
        int errors_before;
        errors_before = errors;
        slow_mem      = slow;
        load_program(kind);
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end
        m_pc    = RESET_PC;
        retired = 0;
        reset_core();
        while (retired < count) begin
            step_cycle();
        end
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("Test %s: %0d retires, %0d errors", name, retired, errors - errors_before);
    endtask

    initial begin
        void'($urandom(32'hd636));
        reset          = 1'b1;
        reset_req      = 1'b1;
        mem_ready      = 1'b0;
        mem_data       = '0;
        mem_data_valid = 1'b0;
        req_open       = 1'b0;
        req_wait       = 0;
        req_addr       = '0;
        ready_low      = 0;
        slow_mem       = 1'b0;
        first_req      = 1'b0;
        m_pc           = RESET_PC;
        errors         = 0;
        checks         = 0;
        retired        = 0;
        failed_tests   = 0;

        run_test("reset", 0, 40, 1'b0);
        run_test("alu_random", 0, 300, 1'b0);
        run_test("dependency", 1, 300, 1'b0);
        run_test("branch", 2, 300, 1'b0);
        run_test("slow_memory", 2, 200, 1'b1);
        run_test("unsupported", 3, 200, 1'b0);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Twenty cycles per retire plus the resets.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the tests did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule
